// ==== src/isa_pkg.sv ====
package isa_pkg;

  localparam int XLEN = 64;  // register and data width

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL     = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;  // plain register op
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;  // selects SUB over ADD

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // one instruction word seen either as R-type or as I-type
  typedef union packed {
    r_type_t r_view;
    i_type_t i_view;
  } instr_u;

endpackage

// ==== src/bus_pkg.sv ====
package bus_pkg;

  localparam int DEFAULT_BUS_DATA_WIDTH = 64;
  localparam int DEFAULT_BUS_TAG_WIDTH  = 13;

  // request word for a fetch, aligned to one 64-bit beat
  function automatic logic [63:0] fetch_word_addr(input logic [63:0] addr);
    return {addr[63:3], 3'b000};
  endfunction

  // instruction half of a 64-bit beat, chosen by pc bit 2
  function automatic logic [31:0] select_instr(input logic [63:0] word,
                                               input logic [63:0] pc);
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter int BUS_DATA_WIDTH = bus_pkg::DEFAULT_BUS_DATA_WIDTH,
  parameter int BUS_TAG_WIDTH  = bus_pkg::DEFAULT_BUS_TAG_WIDTH
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_start,
  input  logic [63:0]               fetch_addr,
  input  logic                      bus_respcyc,
  input  logic                      bus_reqack,
  input  logic [BUS_DATA_WIDTH-1:0] bus_resp,
  input  logic [BUS_TAG_WIDTH-1:0]  bus_resptag,
  output logic                      fetch_done,
  output logic [31:0]               instr,
  output logic                      bus_reqcyc,
  output logic                      bus_respack,
  output logic [BUS_DATA_WIDTH-1:0] bus_req,
  output logic [BUS_TAG_WIDTH-1:0]  bus_reqtag
);
  import bus_pkg::*;

  localparam int LANES = BUS_DATA_WIDTH / 64;  // 64-bit lanes in one bus beat

  typedef enum logic [1:0] {F_IDLE, F_REQ, F_RESP, F_ACK} fstate_t;

  fstate_t                   state;
  logic [63:0]               addr_q;     // address of the outstanding fetch
  logic [BUS_TAG_WIDTH-1:0]  tag_q;      // tag counter, also the outstanding tag
  logic                      hit_q;      // last acknowledged response was ours
  logic [63:0]               lane_idx;
  logic [BUS_DATA_WIDTH-1:0] lane_word;
  logic                      tag_hit;

  assign bus_req    = BUS_DATA_WIDTH'(fetch_word_addr(addr_q));  // stable until acked
  assign bus_reqtag = tag_q;
  assign tag_hit    = (bus_resptag == tag_q);

  // a wider beat holds several 64-bit lanes, the address picks one
  assign lane_idx  = (addr_q >> 3) & 64'(LANES - 1);
  assign lane_word = bus_resp >> (lane_idx * 64);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= F_IDLE;
      bus_reqcyc  <= 1'b0;
      bus_respack <= 1'b0;
      fetch_done  <= 1'b0;
      tag_q       <= '0;
      hit_q       <= 1'b0;
    end else begin
      fetch_done  <= 1'b0;
      bus_respack <= 1'b0;  // ack is a single-cycle pulse
      case (state)
        F_IDLE: if (fetch_start) begin
          bus_reqcyc <= 1'b1;
          tag_q      <= tag_q + 1'b1;  // fresh tag for every request
          state      <= F_REQ;
        end
        F_REQ: if (bus_reqack) begin
          bus_reqcyc <= 1'b0;
          state      <= F_RESP;
        end
        F_RESP: if (bus_respcyc) begin
          bus_respack <= 1'b1;  // stray tags are acked too
          fetch_done  <= tag_hit;
          hit_q       <= tag_hit;
          state       <= F_ACK;
        end
        F_ACK: state <= hit_q ? F_IDLE : F_RESP;  // a stray response keeps us waiting
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) addr_q <= fetch_addr;
    if (state == F_RESP && bus_respcyc && tag_hit) begin
      instr <= select_instr(lane_word[63:0], addr_q);  // held until the next fetch
    end
  end

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder (
  input  logic [31:0]               instr,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  output logic [4:0]                rd,
  output logic [isa_pkg::XLEN-1:0]  imm,
  output logic                      use_imm,
  output isa_pkg::alu_op_t          alu_op,
  output logic                      reg_write,
  output logic                      is_halt
);
  import isa_pkg::*;

  instr_u          word;
  logic [XLEN-1:0] imm_i;     // sign-extended I immediate
  logic [XLEN-1:0] imm_sh;    // shift amount
  logic            shift_ok;  // SLLI/SRLI need the upper imm bits clear

  assign word     = instr;
  assign rs1      = word.r_view.rs1;
  assign rs2      = word.r_view.rs2;
  assign rd       = word.r_view.rd;
  assign imm_i    = {{(XLEN-12){word.i_view.imm12[11]}}, word.i_view.imm12};
  assign imm_sh   = {{(XLEN-6){1'b0}}, word.i_view.imm12[5:0]};
  assign shift_ok = (word.i_view.imm12[11:6] == 6'd0);

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    reg_write = 1'b0;  // anything unrecognised retires as a no-op
    is_halt   = 1'b0;
    case (word.r_view.opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        case ({word.r_view.funct7, word.r_view.funct3})
          {FUNCT7_BASE, FUNCT3_ADD_SUB}: alu_op = ALU_ADD;
          {FUNCT7_SUB, FUNCT3_ADD_SUB}:  alu_op = ALU_SUB;
          {FUNCT7_BASE, FUNCT3_SLL}:     alu_op = ALU_SLL;
          {FUNCT7_BASE, FUNCT3_SLT}:     alu_op = ALU_SLT;
          {FUNCT7_BASE, FUNCT3_XOR}:     alu_op = ALU_XOR;
          {FUNCT7_BASE, FUNCT3_SRL}:     alu_op = ALU_SRL;
          {FUNCT7_BASE, FUNCT3_OR}:      alu_op = ALU_OR;
          {FUNCT7_BASE, FUNCT3_AND}:     alu_op = ALU_AND;
          default:                       reg_write = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        case (word.i_view.funct3)
          FUNCT3_ADD_SUB: alu_op = ALU_ADD;
          FUNCT3_XOR:     alu_op = ALU_XOR;
          FUNCT3_OR:      alu_op = ALU_OR;
          FUNCT3_AND:     alu_op = ALU_AND;
          FUNCT3_SLL: begin
            alu_op    = ALU_SLL;
            imm       = imm_sh;
            reg_write = shift_ok;
          end
          FUNCT3_SRL: begin
            alu_op    = ALU_SRL;
            imm       = imm_sh;
            reg_write = shift_ok;  // SRAI falls out here
          end
          default: reg_write = 1'b0;
        endcase
      end
      OPC_SYSTEM: is_halt = (instr == EBREAK_WORD);
      default: ;
    endcase
  end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_t          op,
  input  logic [isa_pkg::XLEN-1:0]  a,
  input  logic [isa_pkg::XLEN-1:0]  b_reg,
  input  logic [isa_pkg::XLEN-1:0]  imm,
  input  logic                      use_imm,
  output logic [isa_pkg::XLEN-1:0]  result
);
  import isa_pkg::*;

  logic [XLEN-1:0] b;      // second operand after the immediate mux
  logic [5:0]      shamt;

  assign b     = use_imm ? imm : b_reg;
  assign shamt = b[5:0];  // only the low 6 bits count for RV64 shifts

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << shamt;
      ALU_SRL: result = a >> shamt;
      ALU_SLT: result = ($signed(a) < $signed(b)) ? {{(XLEN-1){1'b0}}, 1'b1} : '0;
      default: result = '0;
    endcase
  end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [isa_pkg::XLEN-1:0]  stackptr,
  input  logic                      wr_en,
  input  logic [4:0]                rd,
  input  logic [isa_pkg::XLEN-1:0]  wr_data,
  input  logic [4:0]                rs1,
  input  logic [4:0]                rs2,
  output logic [isa_pkg::XLEN-1:0]  rs1_data,
  output logic [isa_pkg::XLEN-1:0]  rs2_data
);
  import isa_pkg::*;

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (i == 2) ? stackptr : '0;  // x2 starts as the stack pointer
      end
    end else if (wr_en && rd != 5'd0) begin
      regs[rd] <= wr_data;  // x0 writes are dropped
    end
  end

  // asynchronous reads, x0 always reads zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== src/core_control.sv ====
`timescale 1ns/1ps

module core_control (
  input  logic        clk,
  input  logic        reset,
  input  logic [63:0] entry,
  input  logic        fetch_done,
  input  logic        reg_write,
  input  logic        is_halt,
  input  logic [4:0]  rd,
  input  logic [63:0] alu_result,
  output logic        fetch_start,
  output logic [63:0] fetch_addr,
  output logic        wr_en,
  output logic        retire_valid,
  output logic [63:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [63:0] retire_data,
  output logic        halted
);

  typedef enum logic [1:0] {S_FETCH, S_WAIT, S_EXEC, S_HALT} state_t;

  state_t      state;
  logic [63:0] pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_FETCH;
      pc    <= entry;
    end else begin
      case (state)
        S_FETCH: state <= S_WAIT;  // request goes out from here
        S_WAIT: if (fetch_done) state <= S_EXEC;
        S_EXEC: begin
          if (is_halt) begin
            state <= S_HALT;
          end else begin
            pc    <= pc + 64'd4;  // no branches, so always the next word
            state <= S_FETCH;
          end
        end
        S_HALT: state <= S_HALT;  // only reset leaves this
        default: state <= S_FETCH;
      endcase
    end
  end

  assign fetch_start = (state == S_FETCH);
  assign fetch_addr  = pc;

  // the instruction retires in its single EXEC cycle
  assign retire_valid = (state == S_EXEC);
  assign wr_en        = retire_valid && reg_write;
  assign retire_pc    = pc;
  assign retire_rd    = reg_write ? rd : 5'd0;  // no-ops show no destination
  assign retire_data  = reg_write ? alu_result : 64'd0;

  // EBREAK shows as halted already in its retire cycle
  assign halted = (state == S_HALT) || (retire_valid && is_halt);

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter int BUS_DATA_WIDTH = bus_pkg::DEFAULT_BUS_DATA_WIDTH,
  parameter int BUS_TAG_WIDTH  = bus_pkg::DEFAULT_BUS_TAG_WIDTH
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [63:0]               entry,     // pc after reset
  input  logic [63:0]               stackptr,  // x2 after reset
  input  logic                      bus_respcyc,
  input  logic                      bus_reqack,
  input  logic [BUS_DATA_WIDTH-1:0] bus_resp,
  input  logic [BUS_TAG_WIDTH-1:0]  bus_resptag,
  output logic                      bus_reqcyc,
  output logic                      bus_respack,
  output logic [BUS_DATA_WIDTH-1:0] bus_req,
  output logic [BUS_TAG_WIDTH-1:0]  bus_reqtag,
  output logic                      retire_valid,
  output logic [63:0]               retire_pc,
  output logic [4:0]                retire_rd,
  output logic [63:0]               retire_data,
  output logic                      halted
);
  import isa_pkg::*;

  logic        fetch_start;
  logic [63:0] fetch_addr;
  logic        fetch_done;
  logic [31:0] instr;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [63:0] imm;
  logic        use_imm;
  alu_op_t     alu_op;
  logic        reg_write;
  logic        is_halt;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] alu_result;
  logic        wr_en;

  core_control u_control (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .fetch_done   (fetch_done),
    .reg_write    (reg_write),
    .is_halt      (is_halt),
    .rd           (rd),
    .alu_result   (alu_result),
    .fetch_start  (fetch_start),
    .fetch_addr   (fetch_addr),
    .wr_en        (wr_en),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  fetch_unit #(
    .BUS_DATA_WIDTH (BUS_DATA_WIDTH),
    .BUS_TAG_WIDTH  (BUS_TAG_WIDTH)
  ) u_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .bus_respcyc (bus_respcyc),
    .bus_reqack  (bus_reqack),
    .bus_resp    (bus_resp),
    .bus_resptag (bus_resptag),
    .fetch_done  (fetch_done),
    .instr       (instr),
    .bus_reqcyc  (bus_reqcyc),
    .bus_respack (bus_respack),
    .bus_req     (bus_req),
    .bus_reqtag  (bus_reqtag)
  );

  decoder u_decoder (
    .instr     (instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .use_imm   (use_imm),
    .alu_op    (alu_op),
    .reg_write (reg_write),
    .is_halt   (is_halt)
  );

  alu u_alu (
    .op      (alu_op),
    .a       (rs1_data),
    .b_reg   (rs2_data),
    .imm     (imm),
    .use_imm (use_imm),
    .result  (alu_result)
  );

  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .stackptr (stackptr),
    .wr_en    (wr_en),
    .rd       (rd),
    .wr_data  (alu_result),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

// ==== dv/core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions #(
  parameter int BUS_DATA_WIDTH = 64,
  parameter int BUS_TAG_WIDTH  = 13
) (
  input logic                      clk,
  input logic                      reset,
  input logic                      bus_reqcyc,
  input logic                      bus_reqack,
  input logic                      bus_respack,
  input logic                      fetch_done,
  input logic [BUS_DATA_WIDTH-1:0] bus_req,
  input logic [BUS_TAG_WIDTH-1:0]  bus_reqtag
);

  logic outstanding;  // a request was acked and its data has not come back yet

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (bus_reqcyc && bus_reqack) begin
      outstanding <= 1'b1;
    end else if (fetch_done) begin
      outstanding <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
    else $error("bus request changed while waiting for bus_reqack");

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    bus_respack |=> !bus_respack)
    else $error("bus_respack stayed high for more than one cycle");

  single_outstanding: assert property (@(posedge clk) disable iff (reset)
    $rose(bus_reqcyc) |-> !outstanding)
    else $error("new bus request while another one is outstanding");

endmodule

bind core_top core_assertions #(
  .BUS_DATA_WIDTH (BUS_DATA_WIDTH),
  .BUS_TAG_WIDTH  (BUS_TAG_WIDTH)
) u_assertions (
  .clk         (clk),
  .reset       (reset),
  .bus_reqcyc  (bus_reqcyc),
  .bus_reqack  (bus_reqack),
  .bus_respack (bus_respack),
  .fetch_done  (fetch_done),
  .bus_req     (bus_req),
  .bus_reqtag  (bus_reqtag)
);

// ==== dv/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
  import isa_pkg::*;

  localparam int BUS_DATA_WIDTH  = 64;
  localparam int BUS_TAG_WIDTH   = 13;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_INSTR       = 200;
  localparam int QUIET_CYCLES    = 50;  // no bus request may follow EBREAK for this long
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 40 + RESET_CYCLES + QUIET_CYCLES;
  localparam logic [63:0] ENTRY    = 64'h0000_0000_8000_0004;  // first fetch uses upper half
  localparam logic [63:0] STACKPTR = 64'h0000_003f_fff0_0000;

  logic                      clk = 1'b0;
  logic                      reset;
  logic [63:0]               entry;
  logic [63:0]               stackptr;
  logic                      bus_respcyc;
  logic                      bus_reqack;
  logic [BUS_DATA_WIDTH-1:0] bus_resp;
  logic [BUS_TAG_WIDTH-1:0]  bus_resptag;
  logic                      bus_reqcyc;
  logic                      bus_respack;
  logic [BUS_DATA_WIDTH-1:0] bus_req;
  logic [BUS_TAG_WIDTH-1:0]  bus_reqtag;
  logic                      retire_valid;
  logic [63:0]               retire_pc;
  logic [4:0]                retire_rd;
  logic [63:0]               retire_data;
  logic                      halted;

  logic [31:0] prog [NUM_INSTR];
  logic [63:0] model_regs [32];  // architectural register state of the reference
  logic [31:0] rng_state = 32'd32;
  int          retire_count = 0;
  logic        program_done = 1'b0;

  core_top #(
    .BUS_DATA_WIDTH (BUS_DATA_WIDTH),
    .BUS_TAG_WIDTH  (BUS_TAG_WIDTH)
  ) dut (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .stackptr     (stackptr),
    .bus_respcyc  (bus_respcyc),
    .bus_reqack   (bus_reqack),
    .bus_resp     (bus_resp),
    .bus_resptag  (bus_resptag),
    .bus_reqcyc   (bus_reqcyc),
    .bus_respack  (bus_respack),
    .bus_req      (bus_req),
    .bus_reqtag   (bus_reqtag),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int random_delay();
    return int'(next_random() % 32'd6);  // 0 to 5 cycles
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
    instr_u iw;
    iw.r_view = {funct7, rs2, rs1, funct3, rd, OPC_OP};
    return iw;
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd);
    instr_u iw;
    iw.i_view = {imm12, rs1, funct3, rd, OPC_OP_IMM};
    return iw;
  endfunction

  // registers come from x0..x15 so results get reused often
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    r   = next_random();
    rd  = {1'b0, r[3:0]};
    rs1 = {1'b0, r[7:4]};
    rs2 = {1'b0, r[11:8]};
    imm = r[23:12];
    case (r[31:24] % 8'd14)
      0:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_ADD_SUB, rd);
      1:       return encode_r(FUNCT7_SUB, rs2, rs1, FUNCT3_ADD_SUB, rd);
      2:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_AND, rd);
      3:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_OR, rd);
      4:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_XOR, rd);
      5:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_SLL, rd);
      6:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_SRL, rd);
      7:       return encode_r(FUNCT7_BASE, rs2, rs1, FUNCT3_SLT, rd);
      8:       return encode_i(imm, rs1, FUNCT3_ADD_SUB, rd);
      9:       return encode_i(imm, rs1, FUNCT3_AND, rd);
      10:      return encode_i(imm, rs1, FUNCT3_OR, rd);
      11:      return encode_i(imm, rs1, FUNCT3_XOR, rd);
      12:      return encode_i({6'd0, imm[5:0]}, rs1, FUNCT3_SLL, rd);
      default: return encode_i({6'd0, imm[5:0]}, rs1, FUNCT3_SRL, rd);
    endcase
  endfunction

  task automatic build_program();
    prog[0] = encode_i(12'h000, 5'd2, FUNCT3_ADD_SUB, 5'd5);  // x5 reads the initial stack pointer
    prog[1] = encode_i(12'h7ff, 5'd2, FUNCT3_ADD_SUB, 5'd0);  // write to x0 still shows its result
    prog[2] = encode_r(FUNCT7_BASE, 5'd2, 5'd0, FUNCT3_ADD_SUB, 5'd6);  // x0 must read back 0
    prog[3] = encode_i(12'hfff, 5'd0, FUNCT3_ADD_SUB, 5'd7);
    prog[4] = encode_r(FUNCT7_BASE, 5'd0, 5'd7, FUNCT3_SLT, 5'd8);  // signed, -1 < 0
    prog[5] = encode_r(FUNCT7_SUB, 5'd7, 5'd0, FUNCT3_ADD_SUB, 5'd9);
    prog[6] = encode_i(12'h03f, 5'd7, FUNCT3_SRL, 5'd10);
    for (int i = 7; i < NUM_INSTR - 1; i++) begin
      prog[i] = random_instr();
    end
    prog[NUM_INSTR-1] = EBREAK_WORD;
  endtask

  // words outside the program get a pattern built from the whole address
  function automatic logic [31:0] instr_at(input logic [63:0] addr);
    logic [63:0] offset;
    offset = addr - ENTRY;
    if (addr >= ENTRY && offset < 64'(NUM_INSTR * 4)) begin
      return prog[int'(offset >> 2)];
    end else begin
      return addr[31:0] ^ addr[63:32] ^ 32'h5a5a_c3c3;
    end
  endfunction

  function automatic logic [63:0] beat_at(input logic [63:0] addr);
    logic [63:0] base;
    base = {addr[63:3], 3'b000};
    return {instr_at(base + 64'd4), instr_at(base)};
  endfunction

  function automatic logic [63:0] reference_step(input logic [31:0] word,
                                                 output logic [4:0] exp_rd);
    instr_u      iw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] res;
    logic        writes;
    iw     = word;
    a      = model_regs[iw.r_view.rs1];
    b      = model_regs[iw.r_view.rs2];
    imm    = {{52{iw.i_view.imm12[11]}}, iw.i_view.imm12};
    res    = '0;
    writes = 1'b1;
    if (iw.r_view.opcode == OPC_OP) begin
      case ({iw.r_view.funct7, iw.r_view.funct3})
        {FUNCT7_BASE, FUNCT3_ADD_SUB}: res = a + b;
        {FUNCT7_SUB, FUNCT3_ADD_SUB}:  res = a - b;
        {FUNCT7_BASE, FUNCT3_SLL}:     res = a << b[5:0];
        {FUNCT7_BASE, FUNCT3_SLT}:     res = {63'd0, $signed(a) < $signed(b)};
        {FUNCT7_BASE, FUNCT3_XOR}:     res = a ^ b;
        {FUNCT7_BASE, FUNCT3_SRL}:     res = a >> b[5:0];
        {FUNCT7_BASE, FUNCT3_OR}:      res = a | b;
        {FUNCT7_BASE, FUNCT3_AND}:     res = a & b;
        default:                       writes = 1'b0;
      endcase
    end else if (iw.r_view.opcode == OPC_OP_IMM) begin
      case (iw.i_view.funct3)
        FUNCT3_ADD_SUB: res = a + imm;
        FUNCT3_XOR:     res = a ^ imm;
        FUNCT3_OR:      res = a | imm;
        FUNCT3_AND:     res = a & imm;
        FUNCT3_SLL: begin
          res    = a << imm[5:0];
          writes = (imm[11:6] == 6'd0);  // shamt is only 6 bits in RV64
        end
        FUNCT3_SRL: begin
          res    = a >> imm[5:0];
          writes = (imm[11:6] == 6'd0);
        end
        default: writes = 1'b0;
      endcase
    end else begin
      writes = 1'b0;  // EBREAK and unknown encodings touch no register
    end
    if (!writes) begin
      exp_rd = 5'd0;
      return 64'd0;
    end
    exp_rd = iw.r_view.rd;
    if (exp_rd != 5'd0) begin
      model_regs[exp_rd] = res;
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // drive one response and hold it past the edge that samples bus_respack
  task automatic send_response(input logic [BUS_TAG_WIDTH-1:0] tag,
                               input logic [BUS_DATA_WIDTH-1:0] data);
    bus_respcyc = 1'b1;
    bus_resp    = data;
    bus_resptag = tag;
    do @(negedge clk); while (!bus_respack);
    @(negedge clk);
    bus_respcyc = 1'b0;
  endtask

  initial begin : main
    reset    = 1'b1;
    entry    = ENTRY;
    stackptr = STACKPTR;
    build_program();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 64'd0;
    end
    model_regs[2] = STACKPTR;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    wait (program_done);
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_value("bus_reqcyc", 64'(bus_reqcyc), 64'd0);
      check_value("halted", 64'(halted), 64'd1);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin : responder
    logic [63:0]              req_addr;
    logic [63:0]              exp_addr;
    logic [BUS_TAG_WIDTH-1:0] req_tag;
    logic [BUS_TAG_WIDTH-1:0] prev_tag;
    logic [BUS_TAG_WIDTH-1:0] exp_tag;
    logic [63:0]              beat;
    int                       fetch_count;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
    prev_tag    = '0;
    fetch_count = 0;
    forever begin
      @(negedge clk);
      if (!reset && bus_reqcyc) begin
        req_addr = bus_req;
        req_tag  = bus_reqtag;
        exp_addr = ENTRY + 64'(fetch_count * 4);
        // one beat serves both halves, so only the beat address is compared
        check_value("bus_req", {req_addr[63:3], 3'b000}, {exp_addr[63:3], 3'b000});
        if (fetch_count > 0) begin
          exp_tag = prev_tag + 1'b1;  // the tag counter advances once per request
          check_value("bus_reqtag", 64'(req_tag), 64'(exp_tag));
        end
        prev_tag = req_tag;
        beat     = beat_at(req_addr);
        wait_cycles(random_delay());
        bus_reqack = 1'b1;
        @(negedge clk);
        bus_reqack = 1'b0;
        wait_cycles(random_delay());
        // the first fetch always sees a stray response, later ones now and then
        if (fetch_count == 0 || (next_random() % 32'd4) == 32'd0) begin
          send_response(req_tag ^ BUS_TAG_WIDTH'(1), ~beat);
          wait_cycles(random_delay());
        end
        send_response(req_tag, beat);
        fetch_count++;
      end
    end
  end

  initial begin : compare
    logic [31:0] word;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    forever begin
      @(negedge clk);
      if (!reset && retire_valid) begin
        if (retire_count >= NUM_INSTR) begin
          fail_run("an instruction retired after the final EBREAK");
        end
        word     = prog[retire_count];
        exp_data = reference_step(word, exp_rd);
        check_value("retire_pc", retire_pc, ENTRY + 64'(retire_count * 4));
        check_value("retire_rd", 64'(retire_rd), 64'(exp_rd));
        check_value("retire_data", retire_data, exp_data);
        if (word == EBREAK_WORD) begin
          check_value("halted", 64'(halted), 64'd1);
          program_done = 1'b1;
        end else begin
          check_value("halted", 64'(halted), 64'd0);
        end
        retire_count++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("timeout: the core did not halt within the expected time");
  end

endmodule

// ==== files.f ====
src/isa_pkg.sv
src/bus_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/alu.sv
src/register_file.sv
src/core_control.sv
src/core_top.sv
dv/core_assertions.sv
dv/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core \
  -f files.f -Mdir obj_dir -o sim_tb_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  echo "test passed"
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
